/* hw/brew_fsm.sv */
// brew sequence FSM with sensor interlocks, wait windows and registered output pulses
`timescale 1ns/1ps

module brew_fsm (
	input  logic clk,
	input  logic rst,
	input  logic paid,
	input  logic water_ok,
	input  logic grounds_full,
	input  logic temp_ok,
	input  logic beans_ok,
	input  logic window_done,
	input  logic last_cycle,
	output logic charge,
	output logic window_start,
	output logic cycles_load,
	output logic cycles_step,
	output logic busy,
	output logic grind,
	output logic coffee
);

	brew_pkg::brew_state_t state;
	brew_pkg::brew_state_t state_next;
	logic                  enter_wait; // moving into a timed window state

	always_comb begin
		state_next = state;
		case (state)
			brew_pkg::st_pay: begin
				if (paid)
					state_next = brew_pkg::st_water; // credit covers the cup
			end
			brew_pkg::st_water: begin
				if (water_ok)
					state_next = brew_pkg::st_grounds;
			end
			brew_pkg::st_grounds: begin
				if (!grounds_full)
					state_next = brew_pkg::st_select; // room for the spent puck
			end
			brew_pkg::st_select: begin
				if (window_done)
					state_next = brew_pkg::st_heat; // selector latched at window end
			end
			brew_pkg::st_heat: begin
				if (temp_ok)
					state_next = brew_pkg::st_grind;
			end
			brew_pkg::st_grind: begin
				if (last_cycle)
					state_next = brew_pkg::st_dispense;
				else
					state_next = brew_pkg::st_beans;
			end
			brew_pkg::st_beans: begin
				if (beans_ok)
					state_next = brew_pkg::st_grind;
				else
					state_next = brew_pkg::st_refill; // hopper empty, give time to refill
			end
			brew_pkg::st_refill: begin
				// judged once at the end of the window
				if (window_done && beans_ok)
					state_next = brew_pkg::st_grind;
				else if (window_done)
					state_next = brew_pkg::st_select; // no refill, pick cycles again
			end
			brew_pkg::st_dispense: state_next = brew_pkg::st_pay;
			default: state_next = brew_pkg::st_pay;
		endcase
	end

	assign enter_wait = (state_next != state) &&
		(state_next == brew_pkg::st_select || state_next == brew_pkg::st_refill);

	always_ff @(posedge clk) begin
		if (rst) begin
			state        <= brew_pkg::st_pay;
			charge       <= 1'b0;
			window_start <= 1'b0;
			cycles_load  <= 1'b0;
			cycles_step  <= 1'b0;
			grind        <= 1'b0;
			coffee       <= 1'b0;
		end else begin
			state        <= state_next;
			charge       <= (state == brew_pkg::st_pay) && paid; // first cycle of st_water
			window_start <= enter_wait;                           // first cycle of the window state
			cycles_load  <= (state == brew_pkg::st_select) && window_done;
			cycles_step  <= (state == brew_pkg::st_grind) && !last_cycle;
			grind        <= state_next == brew_pkg::st_grind;     // one pulse per grind cycle
			coffee       <= state_next == brew_pkg::st_dispense;
		end
	end

	// a cup is in progress from the charge until dispense is over
	assign busy = state != brew_pkg::st_pay;

	assert property (@(posedge clk) disable iff (rst) !(grind && coffee))
		else $error("grind and coffee high together");

endmodule

/* hw/brew_pkg.sv */
// widths, value types, brew state encoding and default constants for the espresso controller
package brew_pkg;

	// one coin in cents, valid with its strobe
	typedef logic [7:0] coin_t;

	// running credit and the change paid back, holds price plus one maximal coin
	typedef logic [8:0] credit_t;

	// grind selector, code k asks for k+1 cycles
	typedef logic [2:0] sel_t;

	// grind cycles still to run, 0 to 8
	typedef logic [3:0] cycles_t;

	// clk cycles within one second, wide enough for 50 MHz
	typedef logic [25:0] ticks_t;

	// seconds elapsed inside a wait window
	typedef logic [3:0] secs_t;

	// gray-style codes, neighbouring states differ in one bit where possible
	typedef enum logic [3:0] {
		st_pay      = 4'b0001, // collecting coins
		st_water    = 4'b0011, // tank level check
		st_grounds  = 4'b0010, // spent grounds bin check
		st_select   = 4'b0110, // selection window for grind cycles
		st_heat     = 4'b0111, // wait for brewing temperature
		st_grind    = 4'b0101, // one grind cycle
		st_beans    = 4'b0100, // bean sensor check between cycles
		st_refill   = 4'b1100, // one window for a bean refill
		st_dispense = 4'b1101  // pour the cup
	} brew_state_t;

	localparam credit_t DEF_PRICE         = 9'd50;        // cents per cup
	localparam ticks_t  DEF_TICKS_PER_SEC = 26'd50000000; // 50 MHz clk
	localparam secs_t   DEF_WAIT_SECS     = 4'd10;        // selection and refill windows

endpackage

/* hw/coffee_maker.sv */
// espresso controller top level, credit, window timer, grind counter and brew FSM
`timescale 1ns/1ps

module coffee_maker #(
	parameter brew_pkg::credit_t PRICE         = brew_pkg::DEF_PRICE,
	parameter brew_pkg::ticks_t  TICKS_PER_SEC = brew_pkg::DEF_TICKS_PER_SEC,
	parameter brew_pkg::secs_t   WAIT_SECS     = brew_pkg::DEF_WAIT_SECS
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              coin_strobe,
	input  brew_pkg::coin_t   coin_value,
	input  logic              water_ok,
	input  logic              grounds_full,
	input  logic              temp_ok,
	input  logic              beans_ok,
	input  brew_pkg::sel_t    grind_sel,
	output logic              busy,
	output logic              grind,
	output logic              coffee,
	output logic              change_strobe,
	output brew_pkg::credit_t change
);

	logic paid;         // credit covers the price
	logic charge;       // FSM takes the money
	logic window_start; // selection or refill window begins
	logic window_done;  // window elapsed
	logic cycles_load;  // latch grind_sel+1
	logic cycles_step;  // one grind cycle done
	logic last_cycle;   // final grind cycle pending

	coin_credit #(.PRICE(PRICE)) u_credit (
		.clk(clk), .rst(rst),
		.coin_strobe(coin_strobe), .coin_value(coin_value),
		.busy(busy), .charge(charge), .paid(paid),
		.change_strobe(change_strobe), .change(change)
	);

	wait_timer #(.TICKS_PER_SEC(TICKS_PER_SEC), .WAIT_SECS(WAIT_SECS)) u_timer (
		.clk(clk), .rst(rst),
		.window_start(window_start), .window_done(window_done)
	);

	grind_counter u_cycles (
		.clk(clk), .rst(rst), .grind_sel(grind_sel),
		.cycles_load(cycles_load), .cycles_step(cycles_step), .last_cycle(last_cycle)
	);

	brew_fsm u_fsm (
		.clk(clk), .rst(rst), .paid(paid),
		.water_ok(water_ok), .grounds_full(grounds_full),
		.temp_ok(temp_ok), .beans_ok(beans_ok),
		.window_done(window_done), .last_cycle(last_cycle),
		.charge(charge), .window_start(window_start),
		.cycles_load(cycles_load), .cycles_step(cycles_step),
		.busy(busy), .grind(grind), .coffee(coffee)
	);

endmodule

/* hw/coin_credit.sv */
// coin accumulator with price compare and change return on charge
`timescale 1ns/1ps

module coin_credit #(
	parameter brew_pkg::credit_t PRICE
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              coin_strobe,
	input  brew_pkg::coin_t   coin_value,
	input  logic              busy,
	input  logic              charge,
	output logic              paid,
	output logic              change_strobe,
	output brew_pkg::credit_t change
);

	brew_pkg::credit_t credit; // running total of accepted coins
	logic              coin_take;

	// coins count only between cups and until the price is covered,
	// so the credit never grows past price plus one coin
	assign coin_take = coin_strobe && !busy && !paid;

	assign paid = credit >= PRICE; // level, stays up until the charge clears it

	always_ff @(posedge clk) begin
		if (rst) begin
			credit        <= '0;
			change_strobe <= 1'b0;
		end else begin
			change_strobe <= 1'b0; // single cycle pulse
			if (charge) begin
				credit        <= '0; // cup paid, start over
				change_strobe <= credit != PRICE; // nothing to return on exact pay
			end else if (coin_take) begin
				credit <= credit + {1'b0, coin_value}; // zero extend to credit width
			end
		end
	end

	// change value, qualified by change_strobe
	always_ff @(posedge clk) begin
		if (charge) begin
			change <= credit - PRICE;
		end
	end

	// the brew FSM may only charge a cup that the credit covers
	assert property (@(posedge clk) disable iff (rst) charge |-> paid)
		else $error("charge pulse without enough credit");

endmodule

/* hw/grind_counter.sv */
// remaining grind cycles, loaded from the selector and stepped down per cycle
`timescale 1ns/1ps

module grind_counter (
	input  logic           clk,
	input  logic           rst,
	input  brew_pkg::sel_t grind_sel,
	input  logic           cycles_load,
	input  logic           cycles_step,
	output logic           last_cycle
);

	brew_pkg::cycles_t count; // cycles still to grind, 0 to 8

	always_ff @(posedge clk) begin
		if (rst) begin
			count <= '0;
		end else if (cycles_load) begin
			// selector code k means k+1 cycles, sampled with the load pulse
			count <= {1'b0, grind_sel} + 4'd1;
		end else if (cycles_step) begin
			count <= count - 4'd1;
		end
	end

	// the cycle now grinding is the final one
	assign last_cycle = count == 4'd1;

	// the FSM steps only after a cycle that was not the last one,
	// so a step never meets an empty or final count
	assert property (@(posedge clk) disable iff (rst) cycles_step |-> count > 4'd1)
		else $error("grind step with count %0d", count);

endmodule

/* hw/wait_timer.sv */
// seconds prescaler and window counter for the selection and refill waits
`timescale 1ns/1ps

module wait_timer #(
	parameter brew_pkg::ticks_t TICKS_PER_SEC,
	parameter brew_pkg::secs_t  WAIT_SECS
) (
	input  logic clk,
	input  logic rst,
	input  logic window_start,
	output logic window_done
);

	localparam brew_pkg::ticks_t TICK_LAST = TICKS_PER_SEC - brew_pkg::ticks_t'(1);
	localparam brew_pkg::secs_t  SEC_LAST  = WAIT_SECS - brew_pkg::secs_t'(1);

	logic             active; // a window is running
	brew_pkg::ticks_t ticks;  // clk cycles into the current second
	brew_pkg::secs_t  secs;   // whole seconds into the window
	logic             sec_end;

	assign sec_end = ticks == TICK_LAST;

	// last cycle of the last second, lands WAIT_SECS*TICKS_PER_SEC cycles after start
	assign window_done = active && sec_end && (secs == SEC_LAST);

	always_ff @(posedge clk) begin
		if (rst) begin
			active <= 1'b0;
			ticks  <= '0;
			secs   <= '0;
		end else if (window_start) begin
			active <= 1'b1; // a new start always restarts the count
			ticks  <= '0;
			secs   <= '0;
		end else if (active) begin
			if (window_done) begin
				active <= 1'b0; // back to idle until the next start
				ticks  <= '0;
				secs   <= '0;
			end else if (sec_end) begin
				ticks <= '0;
				secs  <= secs + 1'b1; // one more second gone
			end else begin
				ticks <= ticks + 1'b1;
			end
		end
	end

	assert property (@(posedge clk) disable iff (rst) window_done |=> !window_done)
		else $error("window_done held for more than one cycle");

endmodule

/* run.sh */
#!/usr/bin/env bash
# build the espresso controller testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f tb.f --top-module tb_coffee_maker -o tb_sim
status=$?
if [ $status -ne 0 ]; then
	echo "build failed with status $status"
	exit $status
fi

./obj_dir/tb_sim
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi

echo "simulation finished cleanly"
exit 0

/* tb.f */
hw/brew_pkg.sv
hw/coin_credit.sv
hw/wait_timer.sv
hw/grind_counter.sv
hw/brew_fsm.sv
hw/coffee_maker.sv
tb/tb_coffee_maker.sv

/* tb/tb_coffee_maker.sv */
// testbench for the espresso controller with stimulus tasks, reference model, monitor and checks
`timescale 1ns/1ps

module tb_coffee_maker;

	localparam brew_pkg::credit_t PRICE = 9'd50; // cents per cup
	localparam int WINDOW = 40;                  // 10 s window at 4 ticks per second

	logic              clk;
	logic              rst;
	logic              coin_strobe;
	brew_pkg::coin_t   coin_value;
	logic              water_ok;
	logic              grounds_full;
	logic              temp_ok;
	logic              beans_ok;
	brew_pkg::sel_t    grind_sel;
	logic              busy;
	logic              grind;
	logic              coffee;
	logic              change_strobe;
	brew_pkg::credit_t change;

	int                grind_count = 0;  // pulses seen since reset
	int                coffee_count = 0;
	int                change_count = 0;
	brew_pkg::credit_t change_seen = '0; // value of the latest change pulse
	int                grind_base;       // counter values when the cup started
	int                coffee_base;
	int                change_base;
	brew_pkg::coin_t   coin_list[$];     // coins for the next cup, in insertion order

	coffee_maker #(
		.PRICE(PRICE), .TICKS_PER_SEC(brew_pkg::ticks_t'(4)), .WAIT_SECS(brew_pkg::secs_t'(10))
	) UUT (
		.clk(clk), .rst(rst), .coin_strobe(coin_strobe), .coin_value(coin_value),
		.water_ok(water_ok), .grounds_full(grounds_full), .temp_ok(temp_ok),
		.beans_ok(beans_ok), .grind_sel(grind_sel), .busy(busy), .grind(grind),
		.coffee(coffee), .change_strobe(change_strobe), .change(change)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk; // 40 ns period
	end

	// outputs are registered, so mid-cycle sampling sees settled values
	always @(negedge clk) begin
		if (!rst) begin
			if (grind)
				grind_count++;
			if (coffee)
				coffee_count++;
			if (change_strobe) begin
				change_count++;
				change_seen = change; // change is valid with its strobe
			end
		end
	end

	// change owed at the moment the running credit first covers the price
	function automatic brew_pkg::credit_t expected_change(input brew_pkg::coin_t coins[$],
		input brew_pkg::credit_t price);
		int sum;
		sum = 0;
		foreach (coins[i]) begin
			sum += int'(coins[i]);
			if (sum >= int'(price))
				return brew_pkg::credit_t'(sum - int'(price)); // later coins are dropped
		end
		return '0;
	endfunction

	task automatic fail_run();
		$display("TESTBENCH FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_change(input string name, input brew_pkg::credit_t expected,
		input brew_pkg::credit_t actual);
		if (actual !== expected) begin
			$display("Error %s: expected %0d, actual %0d", name, expected, actual);
			fail_run();
		end
	endtask

	task automatic check_cycles(input string name, input brew_pkg::cycles_t expected,
		input brew_pkg::cycles_t actual);
		if (actual !== expected) begin
			$display("Error %s: expected %0d, actual %0d", name, expected, actual);
			fail_run();
		end
	endtask

	task automatic check_level(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("Error %s: expected %b, actual %b", name, expected, actual);
			fail_run();
		end
	endtask

	task automatic check_count(input string name, input int expected, input int actual);
		if (actual != expected) begin
			$display("Error %s: expected %0d, actual %0d", name, expected, actual);
			fail_run();
		end
	endtask

	task automatic wait_grinds(input int target, input int limit);
		int n;
		n = 0;
		while (grind_count < target) begin
			@(posedge clk); // counters move on falling edges only
			n++;
			if (n > limit) begin
				$display("timeout: grind pulse missing after %0d cycles", limit);
				fail_run();
			end
		end
	endtask

	task automatic wait_coffee(input int target, input int limit);
		int n;
		n = 0;
		while (coffee_count < target) begin
			@(posedge clk);
			n++;
			if (n > limit) begin
				$display("timeout: no coffee pulse within %0d cycles", limit);
				fail_run();
			end
		end
	endtask

	task automatic wait_idle(input int limit);
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
			if (n > limit) begin
				$display("timeout: busy still high %0d cycles after coffee", limit);
				fail_run();
			end
		end while (busy);
	endtask

	task automatic wait_reselect(input int limit);
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
			if (n > limit) begin
				$display("timeout: controller never went back to cup selection");
				fail_run();
			end
		end while (UUT.u_fsm.state != brew_pkg::st_select);
	endtask

	task automatic fill_exact();
		int left;
		int c;
		coin_list.delete();
		left = int'(PRICE);
		while (left > 0) begin
			c = 5 * (1 + int'($urandom % 4)); // 5 to 20 cents
			if (c > left)
				c = left;
			coin_list.push_back(brew_pkg::coin_t'(c));
			left -= c;
		end
	endtask

	task automatic fill_over();
		int sum;
		int c;
		coin_list.delete();
		sum = 0;
		while (sum < int'(PRICE)) begin
			c = 1 + int'($urandom % 60);
			if (sum + c == int'(PRICE))
				c++; // force some change back
			coin_list.push_back(brew_pkg::coin_t'(c));
			sum += c;
		end
		coin_list.push_back(brew_pkg::coin_t'(1 + $urandom % 60)); // lands after paid, dropped
	endtask

	// snapshot counters, set the selector and feed one coin per cycle
	task automatic start_cup(input int sel);
		@(posedge clk);
		grind_base  = grind_count;
		coffee_base = coffee_count;
		change_base = change_count;
		@(negedge clk);
		grind_sel = brew_pkg::sel_t'(sel);
		foreach (coin_list[i]) begin
			coin_strobe = 1'b1;
			coin_value  = coin_list[i];
			@(negedge clk);
		end
		coin_strobe = 1'b0;
	endtask

	task automatic finish_cup(input string name, input int grinds, input int changes);
		wait_coffee(coffee_base + 1, 6 * WINDOW);
		wait_idle(10);
		@(posedge clk);
		check_cycles(name, brew_pkg::cycles_t'(grinds),
			brew_pkg::cycles_t'(grind_count - grind_base));
		check_count({name, " coffee"}, coffee_base + 1, coffee_count);
		check_count({name, " change pulses"}, change_base + changes, change_count);
	endtask

	// sensor interlock held, nothing may grind or pour meanwhile
	task automatic check_stalled(input string name, input int cycles);
		repeat (cycles) begin
			@(negedge clk);
			check_level({name, " busy"}, 1'b1, busy);
			check_level({name, " grind"}, 1'b0, grind);
			check_level({name, " coffee"}, 1'b0, coffee);
		end
	endtask

	task automatic test_exact_pay();
		int sel;
		sel = int'($urandom % 8);
		fill_exact();
		start_cup(sel);
		finish_cup("exact_pay", sel + 1, 0);
	endtask

	task automatic test_overpay();
		int sel;
		sel = int'($urandom % 8);
		fill_over();
		start_cup(sel);
		finish_cup("overpay", sel + 1, 1);
		check_change("overpay", expected_change(coin_list, PRICE), change_seen);
	endtask

	task automatic test_interlocks();
		int sel;
		sel = int'($urandom % 8);
		fill_exact();
		@(negedge clk);
		water_ok = 1'b0; // tank low, every later sensor ready
		start_cup(sel);
		check_stalled("interlock water", 100);
		water_ok     = 1'b1;
		grounds_full = 1'b1; // bin full by the time the FSM gets there
		check_stalled("interlock grounds", 100);
		grounds_full = 1'b0;
		temp_ok      = 1'b0; // boiler cold before the selection window ends
		check_stalled("interlock heat", 100); // covers the selection window too
		temp_ok = 1'b1;
		finish_cup("interlocks", sel + 1, 0);
	endtask

	task automatic test_refill_ok();
		int sel;
		sel = 1 + int'($urandom % 7); // at least two cycles, so a bean check happens
		fill_exact();
		start_cup(sel);
		wait_grinds(grind_base + 1, 3 * WINDOW);
		@(negedge clk);
		beans_ok = 1'b0; // bean check after the first cycle fails
		repeat (WINDOW / 4) @(negedge clk);
		beans_ok = 1'b1; // refill well inside the window
		finish_cup("refill_ok", sel + 1, 0);
	endtask

	task automatic test_refill_timeout();
		int sel;
		int sel_new;
		sel     = 1 + int'($urandom % 7);
		sel_new = int'($urandom % 8);
		fill_exact();
		start_cup(sel);
		wait_grinds(grind_base + 1, 3 * WINDOW);
		@(negedge clk);
		beans_ok = 1'b0;
		wait_reselect(3 * WINDOW); // refill window ran out
		@(posedge clk);
		check_cycles("refill_timeout first", brew_pkg::cycles_t'(1),
			brew_pkg::cycles_t'(grind_count - grind_base));
		grind_base = grind_count;
		@(negedge clk);
		grind_sel = brew_pkg::sel_t'(sel_new); // new pick inside the selection window
		repeat (5) @(negedge clk);
		beans_ok = 1'b1;
		finish_cup("refill_timeout", sel_new + 1, 0);
	endtask

	initial begin
		void'($urandom(32'h46d06122));
		rst          = 1'b1;
		coin_strobe  = 1'b0;
		coin_value   = '0;
		water_ok     = 1'b1;
		grounds_full = 1'b0;
		temp_ok      = 1'b1;
		beans_ok     = 1'b1;
		grind_sel    = '0;
		repeat (10) @(negedge clk);
		rst = 1'b0;
		test_exact_pay();
		test_overpay();
		test_interlocks();
		test_refill_ok();
		test_refill_timeout();
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule
